//--- logic/yaw_types_pkg.sv
/*
 * Yaw accumulator data types
 * Widths and vector types for angles, receiver values and the mode switch.
 * Angles are signed with four fraction bits (sixteenths of a degree).
 */
`default_nettype none

package yaw_types_pkg;

	// Angle and normalized stick width
	localparam int ANGLE_WIDTH = 16;

	// Receiver value width
	localparam int PWM_WIDTH = 8;

	// Angle, normalized stick and scaled heading
	typedef logic signed [ANGLE_WIDTH-1:0] angle_t;

	// Raw receiver value, 0 to 250
	typedef logic [PWM_WIDTH-1:0] pwm_t;

	// Transmitter mode switch
	typedef logic [2:0] mode_sel_t;

endpackage

`default_nettype wire

//--- logic/yaw_angle_pkg.sv
/*
 * Yaw accumulator angle constants
 * Angles in IMU units (16 counts per degree), the idle throttle limit,
 * the stick deadband and the switch code that enables the stick gain.
 */
`default_nettype none

package yaw_angle_pkg;

	// Full turn and quarter points, 16 counts per degree
	localparam yaw_types_pkg::angle_t ANGLE_360 = 16'sd5760;
	localparam yaw_types_pkg::angle_t ANGLE_270 = 16'sd4320;
	localparam yaw_types_pkg::angle_t ANGLE_90 = 16'sd1440;
	localparam yaw_types_pkg::angle_t ANGLE_0 = 16'sd0;

	// Throttle below this counts as motors off
	localparam yaw_types_pkg::pwm_t THROTTLE_IDLE_LIMIT = 8'd10;

	// Stick strictly inside +/- this value counts as neutral
	localparam yaw_types_pkg::angle_t STICK_DEADBAND = 16'sd4;

	// Switch A position that turns on the stick gain
	localparam yaw_types_pkg::mode_sel_t GAIN_SELECT = 3'd1;

endpackage

`default_nettype wire

//--- logic/yaw_sequencer.sv
/*
 * Yaw accumulator sequencer
 * Latches the start level and steps through one fixed-length pass,
 * raising a one-cycle strobe for each datapath step.
 * Active covers the compute steps, complete pulses once at the end.
 */
`timescale 1ns/1ps
`default_nettype none

module yaw_sequencer (
	input  wire logic us_clk,
	input  wire logic resetn,
	input  wire logic start_signal,
	input  wire logic imu_ready,
	output logic latch_step,
	output logic neutral_step,
	output logic normalize_step,
	output logic window_step,
	output logic sum_step,
	output logic track_step,
	output logic rollback_step,
	output logic scale_step,
	output logic diff_step,
	output logic error_step,
	output logic hold_step,
	output logic output_step,
	output logic init_clear,
	output logic active_signal,
	output logic complete_signal
);

	typedef enum logic [3:0] {
		ST_INIT,
		ST_WAITING,
		ST_LATCH,
		ST_NEUTRAL,
		ST_NORMALIZE,
		ST_WINDOW,
		ST_SUM,
		ST_TRACK,
		ST_ROLLBACK,
		ST_SCALE,
		ST_DIFF,
		ST_ERROR,
		ST_HOLD,
		ST_OUTPUT,
		ST_COMPLETE
	} seq_state_t;

	seq_state_t state;
	seq_state_t next_state;
	logic start_flag;

	// Start level is held until the pass has begun
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_flag <= 1'b0;
		end else if (start_signal) begin
			start_flag <= 1'b1;
		end else if (state != ST_WAITING) begin
			start_flag <= 1'b0;
		end
	end

	always_comb begin
		case (state)
			ST_INIT:      next_state = imu_ready ? ST_WAITING : ST_INIT;
			ST_WAITING:   next_state = start_flag ? ST_LATCH : ST_WAITING;
			ST_LATCH:     next_state = ST_NEUTRAL;
			ST_NEUTRAL:   next_state = ST_NORMALIZE;
			ST_NORMALIZE: next_state = ST_WINDOW;
			ST_WINDOW:    next_state = ST_SUM;
			ST_SUM:       next_state = ST_TRACK;
			ST_TRACK:     next_state = ST_ROLLBACK;
			ST_ROLLBACK:  next_state = ST_SCALE;
			ST_SCALE:     next_state = ST_DIFF;
			ST_DIFF:      next_state = ST_ERROR;
			ST_ERROR:     next_state = ST_HOLD;
			ST_HOLD:      next_state = ST_OUTPUT;
			ST_OUTPUT:    next_state = ST_COMPLETE;
			ST_COMPLETE:  next_state = ST_WAITING;
			default:      next_state = ST_INIT;
		endcase
	end

	// Active follows the state being entered, so it rises with the first step
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= ST_INIT;
			active_signal <= 1'b0;
			complete_signal <= 1'b0;
		end else begin
			state <= next_state;
			active_signal <= (next_state != ST_INIT) && (next_state != ST_WAITING);
			// Also high during init so downstream blocks can start
			complete_signal <= (state == ST_INIT) || (state == ST_COMPLETE);
		end
	end

	assign init_clear = (state == ST_INIT);
	assign latch_step = (state == ST_LATCH);
	assign neutral_step = (state == ST_NEUTRAL);
	assign normalize_step = (state == ST_NORMALIZE);
	assign window_step = (state == ST_WINDOW);
	assign sum_step = (state == ST_SUM);
	assign track_step = (state == ST_TRACK);
	assign rollback_step = (state == ST_ROLLBACK);
	assign scale_step = (state == ST_SCALE);
	assign diff_step = (state == ST_DIFF);
	assign error_step = (state == ST_ERROR);
	assign hold_step = (state == ST_HOLD);
	assign output_step = (state == ST_OUTPUT);

endmodule

`default_nettype wire

//--- logic/yaw_stick_sampler.sv
/*
 * Yaw stick sampler
 * Latches the receiver and IMU inputs for a pass, rejecting IMU angles
 * outside 0 to 360 degrees. Captures the stick neutral point while the
 * throttle is idle and produces the normalized stick and deadband flag.
 */
`timescale 1ns/1ps
`default_nettype none

module yaw_stick_sampler #(
	parameter int STICK_GAIN = 4
) (
	input  wire logic us_clk,
	input  wire logic resetn,
	input  wire logic latch_step,
	input  wire logic neutral_step,
	input  wire logic normalize_step,
	input  wire logic window_step,
	input  wire logic init_clear,
	input  wire yaw_types_pkg::pwm_t throttle_pwm_value_input,
	input  wire yaw_types_pkg::pwm_t yaw_pwm_value_input,
	input  wire yaw_types_pkg::angle_t yaw_angle_imu,
	input  wire yaw_types_pkg::mode_sel_t switch_a,
	output logic throttle_idle,
	output yaw_types_pkg::angle_t yaw_angle,
	output yaw_types_pkg::angle_t yaw_raw,
	output yaw_types_pkg::angle_t stick_norm,
	output logic stick_active
);

	localparam int PAD_BITS = yaw_types_pkg::ANGLE_WIDTH - yaw_types_pkg::PWM_WIDTH;

	yaw_types_pkg::pwm_t throttle_q;
	yaw_types_pkg::pwm_t yaw_q;
	yaw_types_pkg::pwm_t neutral_q;
	yaw_types_pkg::angle_t stick_diff;
	logic gain_on;
	logic imu_valid;

	assign throttle_idle = (throttle_q < yaw_angle_pkg::THROTTLE_IDLE_LIMIT);
	assign yaw_raw = {{PAD_BITS{1'b0}}, yaw_q};
	assign stick_diff = yaw_raw - {{PAD_BITS{1'b0}}, neutral_q};

	// IMU glitches show up as angles outside a full turn
	assign imu_valid = (yaw_angle_imu >= yaw_angle_pkg::ANGLE_0) &&
		(yaw_angle_imu <= yaw_angle_pkg::ANGLE_360);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			throttle_q <= '0;
			yaw_q <= '0;
			neutral_q <= '0;
			yaw_angle <= '0;
			gain_on <= 1'b0;
			stick_norm <= '0;
			stick_active <= 1'b0;
		end else if (init_clear) begin
			throttle_q <= '0;
			yaw_q <= '0;
			neutral_q <= '0;
			yaw_angle <= '0;
			gain_on <= 1'b0;
			stick_norm <= '0;
			stick_active <= 1'b0;
		end else begin
			if (latch_step) begin
				throttle_q <= throttle_pwm_value_input;
				yaw_q <= yaw_pwm_value_input;
				gain_on <= (switch_a == yaw_angle_pkg::GAIN_SELECT);
				// Keep the last good angle on a bad sample
				if (imu_valid) begin
					yaw_angle <= yaw_angle_imu;
				end
			end
			// Neutral point only moves while the motors are off
			if (neutral_step && throttle_idle) begin
				neutral_q <= yaw_q;
			end
			if (normalize_step) begin
				stick_norm <= gain_on ? yaw_types_pkg::angle_t'(stick_diff * STICK_GAIN)
					: stick_diff;
			end
			if (window_step) begin
				stick_active <= !throttle_idle &&
					((stick_norm >= yaw_angle_pkg::STICK_DEADBAND) ||
					(stick_norm <= -yaw_angle_pkg::STICK_DEADBAND));
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/yaw_target_tracker.sv
/*
 * Yaw target tracker
 * Accumulates the normalized stick into a heading kept with SCALE_BITS
 * extra fraction bits, wrapping at 360 degrees. A step that would push
 * an already saturated error further is undone.
 */
`timescale 1ns/1ps
`default_nettype none

module yaw_target_tracker #(
	parameter int SCALE_BITS = 2
) (
	input  wire logic us_clk,
	input  wire logic resetn,
	input  wire logic sum_step,
	input  wire logic track_step,
	input  wire logic rollback_step,
	input  wire logic output_step,
	input  wire logic init_clear,
	input  wire logic throttle_idle,
	input  wire logic stick_active,
	input  wire yaw_types_pkg::angle_t stick_norm,
	input  wire yaw_types_pkg::angle_t yaw_angle,
	input  wire yaw_types_pkg::angle_t yaw_angle_error,
	output yaw_types_pkg::angle_t track_angle
);

	localparam yaw_types_pkg::angle_t ANGLE_360_SCALED =
		yaw_types_pkg::angle_t'(int'(yaw_angle_pkg::ANGLE_360) << SCALE_BITS);

	yaw_types_pkg::angle_t track_sum;
	yaw_types_pkg::angle_t track_saved;
	logic error_saturated;

	// Error already at a limit and the stick pushes the same way
	assign error_saturated =
		((yaw_angle_error >= yaw_angle_pkg::ANGLE_90) && (stick_norm > 0)) ||
		((yaw_angle_error <= -yaw_angle_pkg::ANGLE_90) && (stick_norm < 0));

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			track_sum <= '0;
			track_angle <= '0;
			track_saved <= '0;
		end else if (init_clear) begin
			track_sum <= '0;
			track_angle <= '0;
			track_saved <= '0;
		end else begin
			if (sum_step) begin
				track_sum <= track_angle + stick_norm;
			end
			if (track_step) begin
				if (throttle_idle) begin
					// Motors off, heading follows the IMU
					track_angle <= yaw_angle <<< SCALE_BITS;
				end else if (stick_active) begin
					if (track_sum > ANGLE_360_SCALED) begin
						track_angle <= track_sum - ANGLE_360_SCALED;
					end else if (track_sum < yaw_angle_pkg::ANGLE_0) begin
						track_angle <= track_sum + ANGLE_360_SCALED;
					end else begin
						track_angle <= track_sum;
					end
				end
			end else if (rollback_step && error_saturated) begin
				track_angle <= track_saved;
			end
			// Heading at the end of a pass is the rollback point for the next
			if (output_step) begin
				track_saved <= track_angle;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/yaw_error_stage.sv
/*
 * Yaw error stage
 * Scales the tracked heading back to IMU units and computes the signed
 * heading error across the 0/360 degree seam. The error is held rather
 * than flipping sign at +/-90 degrees and clamped on output.
 * With the accumulator disabled the yaw stick passes straight through.
 */
`timescale 1ns/1ps
`default_nettype none

module yaw_error_stage #(
	parameter int SCALE_BITS = 2
) (
	input  wire logic us_clk,
	input  wire logic resetn,
	input  wire logic scale_step,
	input  wire logic diff_step,
	input  wire logic error_step,
	input  wire logic hold_step,
	input  wire logic output_step,
	input  wire logic init_clear,
	input  wire logic throttle_idle,
	input  wire yaw_types_pkg::angle_t yaw_angle,
	input  wire yaw_types_pkg::angle_t yaw_raw,
	input  wire yaw_types_pkg::angle_t track_angle,
	input  wire logic yaac_enable_n,
	output yaw_types_pkg::angle_t yaw_angle_error,
	output yaw_types_pkg::angle_t body_yaw_angle_target,
	output yaw_types_pkg::angle_t yaw_angle_error_out
);

	yaw_types_pkg::angle_t angle_diff;
	yaw_types_pkg::angle_t error_prev;
	logic target_high;
	logic target_low;
	logic imu_high;
	logic imu_low;

	// Quadrant tests for the seam correction
	assign target_high = (body_yaw_angle_target > yaw_angle_pkg::ANGLE_270);
	assign target_low = (body_yaw_angle_target < yaw_angle_pkg::ANGLE_90);
	assign imu_high = (yaw_angle > yaw_angle_pkg::ANGLE_270);
	assign imu_low = (yaw_angle < yaw_angle_pkg::ANGLE_90);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			body_yaw_angle_target <= '0;
			angle_diff <= '0;
			yaw_angle_error <= '0;
			error_prev <= '0;
			yaw_angle_error_out <= '0;
		end else if (init_clear) begin
			body_yaw_angle_target <= '0;
			angle_diff <= '0;
			yaw_angle_error <= '0;
			error_prev <= '0;
			yaw_angle_error_out <= '0;
		end else begin
			if (scale_step) begin
				body_yaw_angle_target <= throttle_idle ? yaw_angle
					: (track_angle >>> SCALE_BITS);
			end
			if (diff_step) begin
				angle_diff <= body_yaw_angle_target - yaw_angle;
			end
			if (error_step) begin
				if (throttle_idle) begin
					yaw_angle_error <= '0;
				end else if (target_high && imu_low) begin
					yaw_angle_error <= -(yaw_angle_pkg::ANGLE_360 - body_yaw_angle_target +
						yaw_angle);
				end else if (imu_high && target_low) begin
					yaw_angle_error <= yaw_angle_pkg::ANGLE_360 - yaw_angle +
						body_yaw_angle_target;
				end else begin
					yaw_angle_error <= angle_diff;
				end
			end
			// Stop the error jumping from one limit to the other
			if (hold_step) begin
				if ((error_prev >= yaw_angle_pkg::ANGLE_90) &&
					(yaw_angle_error <= -yaw_angle_pkg::ANGLE_90)) begin
					yaw_angle_error <= yaw_angle_pkg::ANGLE_90;
				end else if ((error_prev <= -yaw_angle_pkg::ANGLE_90) &&
					(yaw_angle_error >= yaw_angle_pkg::ANGLE_90)) begin
					yaw_angle_error <= -yaw_angle_pkg::ANGLE_90;
				end
			end
			if (output_step) begin
				error_prev <= yaw_angle_error;
				if (yaac_enable_n) begin
					// Bypass, stick value goes out as the target
					body_yaw_angle_target <= yaw_raw;
					yaw_angle_error_out <= '0;
				end else if (yaw_angle_error > yaw_angle_pkg::ANGLE_90) begin
					yaw_angle_error_out <= yaw_angle_pkg::ANGLE_90;
				end else if (yaw_angle_error < -yaw_angle_pkg::ANGLE_90) begin
					yaw_angle_error_out <= -yaw_angle_pkg::ANGLE_90;
				end else begin
					yaw_angle_error_out <= yaw_angle_error;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/yaw_angle_accumulator.sv
/*
 * Yaw angle accumulator
 * Turns yaw stick input into a target heading for the flight controller
 * and reports the heading error against the IMU yaw angle.
 * One pass runs for every start request.
 */
`timescale 1ns/1ps
`default_nettype none

module yaw_angle_accumulator #(
	parameter int SCALE_BITS = 2,
	parameter int STICK_GAIN = 4
) (
	input  wire logic us_clk,
	input  wire logic resetn,
	input  wire logic start_signal,
	input  wire logic imu_ready,
	input  wire yaw_types_pkg::pwm_t throttle_pwm_value_input,
	input  wire yaw_types_pkg::pwm_t yaw_pwm_value_input,
	input  wire yaw_types_pkg::angle_t yaw_angle_imu,
	input  wire logic yaac_enable_n,
	input  wire yaw_types_pkg::mode_sel_t switch_a,
	output yaw_types_pkg::angle_t body_yaw_angle_target,
	output yaw_types_pkg::angle_t yaw_angle_error_out,
	output logic yaw_stick_out_of_neutral_window,
	output logic active_signal,
	output logic complete_signal
);

	logic latch_step;
	logic neutral_step;
	logic normalize_step;
	logic window_step;
	logic sum_step;
	logic track_step;
	logic rollback_step;
	logic scale_step;
	logic diff_step;
	logic error_step;
	logic hold_step;
	logic output_step;
	logic init_clear;
	logic throttle_idle;
	logic stick_active;
	yaw_types_pkg::angle_t yaw_angle;
	yaw_types_pkg::angle_t yaw_raw;
	yaw_types_pkg::angle_t stick_norm;
	yaw_types_pkg::angle_t track_angle;
	yaw_types_pkg::angle_t yaw_angle_error;

	assign yaw_stick_out_of_neutral_window = stick_active;

	yaw_sequencer i_sequencer (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start_signal    (start_signal),
		.imu_ready       (imu_ready),
		.latch_step      (latch_step),
		.neutral_step    (neutral_step),
		.normalize_step  (normalize_step),
		.window_step     (window_step),
		.sum_step        (sum_step),
		.track_step      (track_step),
		.rollback_step   (rollback_step),
		.scale_step      (scale_step),
		.diff_step       (diff_step),
		.error_step      (error_step),
		.hold_step       (hold_step),
		.output_step     (output_step),
		.init_clear      (init_clear),
		.active_signal   (active_signal),
		.complete_signal (complete_signal)
	);

	yaw_stick_sampler #(
		.STICK_GAIN (STICK_GAIN)
	) i_sampler (
		.us_clk                   (us_clk),
		.resetn                   (resetn),
		.latch_step               (latch_step),
		.neutral_step             (neutral_step),
		.normalize_step           (normalize_step),
		.window_step              (window_step),
		.init_clear               (init_clear),
		.throttle_pwm_value_input (throttle_pwm_value_input),
		.yaw_pwm_value_input      (yaw_pwm_value_input),
		.yaw_angle_imu            (yaw_angle_imu),
		.switch_a                 (switch_a),
		.throttle_idle            (throttle_idle),
		.yaw_angle                (yaw_angle),
		.yaw_raw                  (yaw_raw),
		.stick_norm               (stick_norm),
		.stick_active             (stick_active)
	);

	yaw_target_tracker #(
		.SCALE_BITS (SCALE_BITS)
	) i_tracker (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.sum_step        (sum_step),
		.track_step      (track_step),
		.rollback_step   (rollback_step),
		.output_step     (output_step),
		.init_clear      (init_clear),
		.throttle_idle   (throttle_idle),
		.stick_active    (stick_active),
		.stick_norm      (stick_norm),
		.yaw_angle       (yaw_angle),
		.yaw_angle_error (yaw_angle_error),
		.track_angle     (track_angle)
	);

	yaw_error_stage #(
		.SCALE_BITS (SCALE_BITS)
	) i_error (
		.us_clk                (us_clk),
		.resetn                (resetn),
		.scale_step            (scale_step),
		.diff_step             (diff_step),
		.error_step            (error_step),
		.hold_step             (hold_step),
		.output_step           (output_step),
		.init_clear            (init_clear),
		.throttle_idle         (throttle_idle),
		.yaw_angle             (yaw_angle),
		.yaw_raw               (yaw_raw),
		.track_angle           (track_angle),
		.yaac_enable_n         (yaac_enable_n),
		.yaw_angle_error       (yaw_angle_error),
		.body_yaw_angle_target (body_yaw_angle_target),
		.yaw_angle_error_out   (yaw_angle_error_out)
	);

endmodule

`default_nettype wire

//--- tests/yaw_angle_accumulator_props.sv
/*
 * Sequencer properties for the yaw angle accumulator
 * Bound to the sequencer to check the active and complete timing.
 */
`timescale 1ns/1ps
`default_nettype none

module yaw_angle_accumulator_props (
	input wire logic us_clk,
	input wire logic resetn,
	input wire logic init_clear,
	input wire logic active_signal,
	input wire logic complete_signal
);

	logic [4:0] active_run;

	// Length of the current active run
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			active_run <= '0;
		end else if (active_signal) begin
			active_run <= active_run + 5'd1;
		end else begin
			active_run <= '0;
		end
	end

	// Complete after a pass is a single-cycle pulse
	complete_one_cycle: assert property (
		@(posedge us_clk) disable iff (!resetn)
		($rose(complete_signal) && !init_clear) |=> !complete_signal
	) else $error("complete_signal high for more than one cycle after a pass");

	active_complete_exclusive: assert property (
		@(posedge us_clk) disable iff (!resetn)
		!(active_signal && complete_signal)
	) else $error("active_signal and complete_signal high together");

	active_not_too_long: assert property (
		@(posedge us_clk) disable iff (!resetn)
		active_run <= 5'd13
	) else $error("active_signal high for more than 13 cycles");

	active_length: assert property (
		@(posedge us_clk) disable iff (!resetn)
		$fell(active_signal) |-> (active_run == 5'd13)
	) else $error("active_signal run was not 13 cycles long");

endmodule

bind yaw_sequencer yaw_angle_accumulator_props i_props (
	.us_clk          (us_clk),
	.resetn          (resetn),
	.init_clear      (init_clear),
	.active_signal   (active_signal),
	.complete_signal (complete_signal)
);

`default_nettype wire

//--- tests/yaw_angle_accumulator_tb.sv
/*
 * Testbench for the yaw angle accumulator
 * Runs directed passes through the DUT and compares the target, error
 * and window outputs with a reference model of the accumulator rules.
 */
`timescale 1ns/1ps
`default_nettype none

module yaw_angle_accumulator_tb;

	localparam int CLK_HALF = 50;
	localparam int SCALE_BITS = 2;
	localparam int STICK_GAIN = 4;
	localparam int TOTAL_PASSES = 36;
	localparam int PASS_TIMEOUT = 30;
	localparam int WATCHDOG_CYCLES = TOTAL_PASSES * 20 + 200;

	// Angles in sixteenths of a degree
	localparam int FULL_TURN = 5760;
	localparam int THREE_QUARTER = 4320;
	localparam int QUARTER = 1440;
	localparam int IDLE_LIMIT = 10;
	localparam int DEADBAND = 4;
	localparam int GAIN_CODE = 1;

	logic us_clk;
	logic resetn;
	logic start_signal;
	logic imu_ready;
	yaw_types_pkg::pwm_t throttle_pwm_value_input;
	yaw_types_pkg::pwm_t yaw_pwm_value_input;
	yaw_types_pkg::angle_t yaw_angle_imu;
	logic yaac_enable_n;
	yaw_types_pkg::mode_sel_t switch_a;
	yaw_types_pkg::angle_t body_yaw_angle_target;
	yaw_types_pkg::angle_t yaw_angle_error_out;
	logic yaw_stick_out_of_neutral_window;
	logic active_signal;
	logic complete_signal;

	int error_count;
	int check_count;
	int test_count;
	int seed;

	// Reference model state
	int ref_neutral;
	int ref_imu;
	int ref_heading;
	int ref_saved;
	int ref_error_prev;
	int ref_target;
	int ref_error_out;
	bit ref_active;

	yaw_angle_accumulator #(
		.SCALE_BITS (SCALE_BITS),
		.STICK_GAIN (STICK_GAIN)
	) i_dut (
		.us_clk                          (us_clk),
		.resetn                          (resetn),
		.start_signal                    (start_signal),
		.imu_ready                       (imu_ready),
		.throttle_pwm_value_input        (throttle_pwm_value_input),
		.yaw_pwm_value_input             (yaw_pwm_value_input),
		.yaw_angle_imu                   (yaw_angle_imu),
		.yaac_enable_n                   (yaac_enable_n),
		.switch_a                        (switch_a),
		.body_yaw_angle_target           (body_yaw_angle_target),
		.yaw_angle_error_out             (yaw_angle_error_out),
		.yaw_stick_out_of_neutral_window (yaw_stick_out_of_neutral_window),
		.active_signal                   (active_signal),
		.complete_signal                 (complete_signal)
	);

	initial begin
		us_clk = 1'b0;
		forever #CLK_HALF us_clk = ~us_clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge us_clk);
		$display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		$display("Test %s finished with %0d errors", name, error_count - errors_before);
	endtask

	// Keep a value to the 16-bit signed angle range
	function automatic int to_angle(input int value);
		logic signed [15:0] narrow;
		narrow = value[15:0];
		return int'(narrow);
	endfunction

	// One pass of the accumulator rules on the model state
	task automatic model_pass(input int thr, input int yaw, input int imu, input int sw,
		input int bypass);
		int gain;
		int norm;
		int sum;
		int target;
		int err;
		int full_scaled;
		bit idle;
		bit active;
		full_scaled = FULL_TURN << SCALE_BITS;
		idle = (thr < IDLE_LIMIT);
		gain = (sw == GAIN_CODE) ? STICK_GAIN : 1;
		if ((imu >= 0) && (imu <= FULL_TURN)) begin
			ref_imu = imu;
		end
		if (idle) begin
			ref_neutral = yaw;
		end
		norm = to_angle((yaw - ref_neutral) * gain);
		active = !idle && ((norm >= DEADBAND) || (norm <= -DEADBAND));
		sum = to_angle(ref_heading + norm);
		if (idle) begin
			ref_heading = to_angle(ref_imu << SCALE_BITS);
		end else if (active) begin
			if (sum > full_scaled) begin
				ref_heading = sum - full_scaled;
			end else if (sum < 0) begin
				ref_heading = sum + full_scaled;
			end else begin
				ref_heading = sum;
			end
		end
		// Stick pushing a saturated error further is undone
		if (((ref_error_prev >= QUARTER) && (norm > 0)) ||
			((ref_error_prev <= -QUARTER) && (norm < 0))) begin
			ref_heading = ref_saved;
		end
		target = idle ? ref_imu : (ref_heading >>> SCALE_BITS);
		if (idle) begin
			err = 0;
		end else if ((target > THREE_QUARTER) && (ref_imu < QUARTER)) begin
			err = -(FULL_TURN - target + ref_imu);
		end else if ((ref_imu > THREE_QUARTER) && (target < QUARTER)) begin
			err = FULL_TURN - ref_imu + target;
		end else begin
			err = to_angle(target - ref_imu);
		end
		if ((ref_error_prev >= QUARTER) && (err <= -QUARTER)) begin
			err = QUARTER;
		end else if ((ref_error_prev <= -QUARTER) && (err >= QUARTER)) begin
			err = -QUARTER;
		end
		ref_saved = ref_heading;
		ref_error_prev = err;
		ref_active = active;
		if (bypass != 0) begin
			ref_target = yaw;
			ref_error_out = 0;
		end else begin
			ref_target = target;
			ref_error_out = (err > QUARTER) ? QUARTER : ((err < -QUARTER) ? -QUARTER : err);
		end
	endtask

	// Pulse start, wait for the complete pulse, then compare with the model
	task automatic run_pass(input int thr, input int yaw, input int imu, input int sw,
		input int bypass);
		int waited;
		@(negedge us_clk);
		throttle_pwm_value_input = yaw_types_pkg::pwm_t'(thr);
		yaw_pwm_value_input = yaw_types_pkg::pwm_t'(yaw);
		yaw_angle_imu = yaw_types_pkg::angle_t'(imu);
		switch_a = yaw_types_pkg::mode_sel_t'(sw);
		yaac_enable_n = (bypass != 0);
		start_signal = 1'b1;
		@(negedge us_clk);
		start_signal = 1'b0;
		waited = 0;
		while (!complete_signal && (waited < PASS_TIMEOUT)) begin
			@(negedge us_clk);
			waited++;
		end
		if (!complete_signal) begin
			error_count++;
			$display("Pass did not finish within %0d cycles", PASS_TIMEOUT);
		end
		model_pass(thr, yaw, imu, sw, bypass);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), ref_target);
		check_value("yaw_angle_error_out", 32'(yaw_angle_error_out), ref_error_out);
		check_value("yaw_stick_out_of_neutral_window",
			32'(yaw_stick_out_of_neutral_window), 32'(ref_active));
	endtask

	task automatic reset_and_init();
		int errors_before;
		errors_before = error_count;
		repeat (4) @(negedge us_clk);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd0);
		check_value("yaw_angle_error_out", 32'(yaw_angle_error_out), 32'd0);
		check_value("active_signal", 32'(active_signal), 32'd0);
		check_value("complete_signal", 32'(complete_signal), 32'd0);
		resetn = 1'b1;
		// Init holds complete high until the IMU is ready
		repeat (3) @(negedge us_clk);
		check_value("complete_signal", 32'(complete_signal), 32'd1);
		check_value("active_signal", 32'(active_signal), 32'd0);
		imu_ready = 1'b1;
		@(negedge us_clk);
		check_value("complete_signal", 32'(complete_signal), 32'd1);
		@(negedge us_clk);
		check_value("complete_signal", 32'(complete_signal), 32'd0);
		report_test("reset_and_init", errors_before);
	endtask

	task automatic throttle_idle_capture();
		int errors_before;
		errors_before = error_count;
		run_pass(0, 125, 1000, 0, 0);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd1000);
		check_value("yaw_angle_error_out", 32'(yaw_angle_error_out), 32'd0);
		// Throttle on with the stick at neutral holds the heading
		run_pass(100, 125, 1000, 0, 0);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd1000);
		report_test("throttle_idle_capture", errors_before);
	endtask

	task automatic stick_accumulation();
		int errors_before;
		int offset;
		int imu;
		errors_before = error_count;
		run_pass(0, 125, 1000, 0, 0);
		// Just inside the deadband, then on its edge both ways
		run_pass(150, 128, 1000, 0, 0);
		check_value("yaw_stick_out_of_neutral_window",
			32'(yaw_stick_out_of_neutral_window), 32'd0);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd1000);
		run_pass(150, 129, 1000, 0, 0);
		check_value("yaw_stick_out_of_neutral_window",
			32'(yaw_stick_out_of_neutral_window), 32'd1);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd1001);
		run_pass(150, 121, 1000, 0, 0);
		check_value("yaw_stick_out_of_neutral_window",
			32'(yaw_stick_out_of_neutral_window), 32'd1);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd1000);
		for (int i = 0; i < 8; i++) begin
			offset = 8 + int'($random(seed) & 32'h1f);
			imu = 900 + int'($random(seed) & 32'hff);
			// Second half of the passes uses the stick gain
			run_pass(150, 125 + offset, imu, (i < 4) ? 0 : GAIN_CODE, 0);
		end
		report_test("stick_accumulation", errors_before);
	endtask

	task automatic heading_wrap();
		int errors_before;
		errors_before = error_count;
		run_pass(0, 125, 5700, 0, 0);
		run_pass(120, 225, 5700, GAIN_CODE, 0);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd40);
		run_pass(120, 225, 5700, GAIN_CODE, 0);
		run_pass(120, 225, 5700, GAIN_CODE, 0);
		// Backwards through zero
		run_pass(0, 125, 30, 0, 0);
		run_pass(120, 25, 30, GAIN_CODE, 0);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd5690);
		check_value("yaw_angle_error_out", 32'(yaw_angle_error_out), -100);
		run_pass(120, 25, 30, GAIN_CODE, 0);
		run_pass(120, 25, 30, GAIN_CODE, 0);
		report_test("heading_wrap", errors_before);
	endtask

	task automatic error_limits();
		int errors_before;
		errors_before = error_count;
		run_pass(0, 125, 1000, 0, 0);
		run_pass(120, 125, 3000, 0, 0);
		check_value("yaw_angle_error_out", 32'(yaw_angle_error_out), -1440);
		run_pass(120, 105, 3000, GAIN_CODE, 0);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd1000);
		run_pass(120, 100, 3000, GAIN_CODE, 0);
		// Out of range IMU samples keep the last angle
		run_pass(120, 125, 6000, 0, 0);
		run_pass(120, 125, -16, 0, 0);
		check_value("yaw_angle_error_out", 32'(yaw_angle_error_out), -1440);
		// Swing from the negative limit is held there
		run_pass(120, 125, 4400, 0, 0);
		check_value("yaw_angle_error_out", 32'(yaw_angle_error_out), -1440);
		// Positive limit across the seam
		run_pass(0, 125, 1000, 0, 0);
		run_pass(120, 125, 4400, 0, 0);
		check_value("yaw_angle_error_out", 32'(yaw_angle_error_out), 32'd1440);
		run_pass(120, 145, 4400, GAIN_CODE, 0);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd1000);
		// Swing to the other limit is held at the previous one
		run_pass(120, 125, 3000, 0, 0);
		check_value("yaw_angle_error_out", 32'(yaw_angle_error_out), 32'd1440);
		report_test("error_limits", errors_before);
	endtask

	task automatic bypass_mode();
		int errors_before;
		errors_before = error_count;
		run_pass(150, 200, 1000, 0, 1);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd200);
		check_value("yaw_angle_error_out", 32'(yaw_angle_error_out), 32'd0);
		run_pass(150, 50, 1000, 0, 1);
		check_value("body_yaw_angle_target", 32'(body_yaw_angle_target), 32'd50);
		run_pass(150, 125, 1000, 0, 0);
		report_test("bypass_mode", errors_before);
	endtask

	initial begin
		seed = 32'h3b02345d;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		ref_neutral = 0;
		ref_imu = 0;
		ref_heading = 0;
		ref_saved = 0;
		ref_error_prev = 0;
		ref_target = 0;
		ref_error_out = 0;
		ref_active = 1'b0;
		resetn = 1'b0;
		start_signal = 1'b0;
		imu_ready = 1'b0;
		throttle_pwm_value_input = '0;
		yaw_pwm_value_input = '0;
		yaw_angle_imu = '0;
		yaac_enable_n = 1'b0;
		switch_a = '0;
		reset_and_init();
		throttle_idle_capture();
		stick_accumulation();
		heading_wrap();
		error_limits();
		bypass_mode();
		$display("Summary: %0d tests, %0d compares, %0d errors", test_count, check_count,
			error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
logic/yaw_types_pkg.sv
logic/yaw_angle_pkg.sv
logic/yaw_sequencer.sv
logic/yaw_stick_sampler.sv
logic/yaw_target_tracker.sv
logic/yaw_error_stage.sv
logic/yaw_angle_accumulator.sv
tests/yaw_angle_accumulator_props.sv
tests/yaw_angle_accumulator_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the yaw angle accumulator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module yaw_angle_accumulator_tb \
	-f flist.f \
	-o yaw_angle_accumulator_sim

./obj_dir/yaw_angle_accumulator_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed"
exit 1
